// ==== exu_addsub.sv ====
/*
 Adder/subtractor of the ALU. Adds a to b or ~b plus cin, split at
 the word boundary so the carry out of bit 31 is available for icc.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_addsub (
   input  logic [`EXU_DW-1:0] a,
   input  logic [`EXU_DW-1:0] b,
   input  logic               invert,
   input  logic               cin,
   output logic [`EXU_DW-1:0] sum,
   output logic               cout32,
   output logic               cout64,
   output logic               v32,
   output logic               v64
);

   localparam int HW = `EXU_DW / 2;   // Word split point

   logic [`EXU_DW-1:0] b_eff;
   logic [HW:0]        lo;   // Low word plus carry
   logic [HW:0]        hi;

   assign b_eff = invert ? ~b : b;

   assign lo = {1'b0, a[HW-1:0]} + {1'b0, b_eff[HW-1:0]} + {{HW{1'b0}}, cin};
   assign hi = {1'b0, a[`EXU_DW-1:HW]} + {1'b0, b_eff[`EXU_DW-1:HW]}
             + {{HW{1'b0}}, lo[HW]};     // Ripple into upper word

   assign sum    = {hi[HW-1:0], lo[HW-1:0]};
   assign cout32 = lo[HW];
   assign cout64 = hi[HW];

   // Same-sign operands giving a different-sign result
   assign v32 = (a[HW-1] == b_eff[HW-1]) && (sum[HW-1] != a[HW-1]);
   assign v64 = (a[`EXU_DW-1] == b_eff[`EXU_DW-1]) && (sum[`EXU_DW-1] != a[`EXU_DW-1]);

endmodule

// ==== exu_alu.sv ====
/*
 ALU datapath. Holds the E-stage operands, runs the adder, logic unit
 and shifter, picks the result and the load/store address, and
 registers everything on the edge that ends E, with done one cycle
 after issue.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_alu (
   input  logic                rclk,
   input  logic                reset,
   input  logic                issue,
   input  logic [`EXU_DW-1:0]  rs1,
   input  logic [`EXU_DW-1:0]  rs2,
   input  logic [`EXU_DW-1:0]  rs3,
   exu_ctl_if.datapath         ctl,
   exu_flags_if.producer       flags,
   output logic                done,
   output logic [`EXU_DW-1:0]  rd_data,
   output logic [`EXU_VAW-1:0] va,
   output logic                addr_err,
   output logic                rs1_zero,
   output logic                rs1_neg
);

   localparam int HW = `EXU_DW / 2;

   logic [`EXU_DW-1:0] rs1_e, rs2_e, rs3_e;   // E-stage operands
   logic [`EXU_DW-1:0] sum, logic_out, shift_out;
   logic [`EXU_DW-1:0] result;
   logic [`EXU_DW-1:0] zcomp_in;    // Source for zero flags
   logic [`EXU_DW-1:0] va_full;
   logic [`EXU_DW-1:`EXU_VAW-1] va_hi;   // Must be all ones or all zeros

   always_ff @(posedge rclk) begin
      if (issue) begin
         rs1_e <= rs1;
         rs2_e <= rs2;
         rs3_e <= rs3;
      end
   end

   exu_addsub u_addsub (
      .a(rs1_e), .b(rs2_e), .invert(ctl.invert), .cin(ctl.cin), .sum(sum),
      .cout32(flags.cout32), .cout64(flags.cout64), .v32(flags.v32), .v64(flags.v64)
   );

   exu_logic u_logic (
      .a(rs1_e), .b(rs2_e), .invert(ctl.invert), .log_sel(ctl.log_sel),
      .sethi(ctl.sethi), .result(logic_out)
   );

   exu_shift u_shift (
      .a(rs1_e), .amount(rs2_e[`EXU_SHW-1:0]), .shift_left(ctl.shift_left),
      .shift_arith(ctl.shift_arith), .result(shift_out)
   );

   // Result mux
   always_comb begin
      case (ctl.out_sel)
         exu_pkg::OUT_SUM:   result = sum;
         exu_pkg::OUT_RS3:   result = rs3_e;      // CAS swap data
         exu_pkg::OUT_SHIFT: result = shift_out;
         default:            result = logic_out;
      endcase
   end

   // Flags back to control
   assign zcomp_in      = (ctl.out_sel == exu_pkg::OUT_SUM) ? sum : logic_out;
   assign flags.zlow    = ~(|zcomp_in[HW-1:0]);
   assign flags.zhigh   = ~(|zcomp_in[`EXU_DW-1:HW]);
   assign flags.add_n64 = sum[`EXU_DW-1];
   assign flags.add_n32 = sum[HW-1];
   assign flags.log_n64 = logic_out[`EXU_DW-1];
   assign flags.log_n32 = logic_out[HW-1];

   // Address is plain rs1+rs2, no invert or carry; rs1 for CAS
   assign va_full = ctl.casa ? rs1_e : rs1_e + rs2_e;
   assign va_hi   = va_full[`EXU_DW-1:`EXU_VAW-1];

   // Output register, written only for an op in E
   always_ff @(posedge rclk) begin
      if (reset) begin
         done     <= 1'b0;
         rd_data  <= '0;
         va       <= '0;
         addr_err <= 1'b0;
         rs1_zero <= 1'b0;
         rs1_neg  <= 1'b0;
      end else begin
         done <= ctl.e_valid;   // Single pulse per issue
         if (ctl.e_valid) begin
            rd_data  <= result;
            va       <= va_full[`EXU_VAW-1:0];
            addr_err <= ~((&va_hi) | ~(|va_hi));   // Non-canonical
            rs1_zero <= ~(|rs1_e);
            rs1_neg  <= rs1_e[`EXU_DW-1];
         end
      end
   end

endmodule

// ==== exu_consts.svh ====
/*
 Width constants for the integer execute stage.
 Included by every file that sizes a datapath signal.
*/
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_DW  64   // Integer data width
`define EXU_VAW 48   // Virtual address width
`define EXU_SHW 6    // Shift amount width, log2 of data width

`endif

// ==== exu_ctl_if.sv ====
/*
 Decoded E-stage control, driven by the execute control block and
 consumed by the ALU datapath. Valid for the whole E cycle.
*/
`timescale 1ns/1ps

interface exu_ctl_if;
   logic               e_valid;      // Op in E stage
   exu_pkg::out_sel_e  out_sel;      // Result mux select
   exu_pkg::log_sel_e  log_sel;      // Logic function
   logic               invert;       // Invert rs2, sub and the n-type logic ops
   logic               cin;          // Adder carry in
   logic               sethi;        // Clear upper word on move
   logic               shift_left;
   logic               shift_arith;  // Sign fill on right shift
   logic               casa;         // Address from rs1

   modport controller (output e_valid, out_sel, log_sel, invert, cin, sethi,
                       shift_left, shift_arith, casa);
   modport datapath   (input  e_valid, out_sel, log_sel, invert, cin, sethi,
                       shift_left, shift_arith, casa);
endinterface

// ==== exu_ecl.sv ====
/*
 Execute control. Latches the issued opcode into E, decodes it into
 the ALU selects and keeps the condition code register. The carry
 for ADDC/SUBC comes from the ccr written by the previous op.
*/
`timescale 1ns/1ps

module exu_ecl (
   input  logic                   rclk,
   input  logic                   reset,
   input  logic                   issue,
   input  exu_pkg::alu_op_e       op,
   input  logic                   set_cc,
   exu_ctl_if.controller          ctl,
   exu_flags_if.consumer          flags,
   output exu_pkg::ccr_t          ccr
);

   exu_pkg::alu_op_e op_e;
   logic             set_cc_e;
   logic             e_valid;
   logic             is_arith;   // ADD/ADDC/SUB/SUBC
   logic             is_sub;     // Carry flag becomes borrow
   logic             cc_ok;      // Op class may write ccr
   exu_pkg::ccr_t    ccr_nxt;

   // E-stage registers
   always_ff @(posedge rclk) begin
      if (reset) begin
         e_valid  <= 1'b0;
         set_cc_e <= 1'b0;
         op_e     <= exu_pkg::OP_ADD;
      end else begin
         e_valid <= issue;
         if (issue) begin
            op_e     <= op;
            set_cc_e <= set_cc;
         end
      end
   end

   assign ctl.e_valid = e_valid;
   assign is_arith    = (op_e <= exu_pkg::OP_SUBC);
   assign is_sub      = (op_e == exu_pkg::OP_SUB) || (op_e == exu_pkg::OP_SUBC);
   assign cc_ok       = (op_e <= exu_pkg::OP_SETHI);   // Shifts and CAS excluded

   // Opcode decode
   always_comb begin
      ctl.out_sel     = exu_pkg::OUT_LOGIC;
      ctl.log_sel     = exu_pkg::LOG_MOVE;
      ctl.invert      = 1'b0;
      ctl.cin         = 1'b0;
      ctl.sethi       = 1'b0;
      ctl.shift_left  = 1'b0;
      ctl.shift_arith = 1'b0;
      ctl.casa        = 1'b0;
      case (op_e)
         exu_pkg::OP_ADD:   ctl.out_sel = exu_pkg::OUT_SUM;
         exu_pkg::OP_ADDC: begin
            ctl.out_sel = exu_pkg::OUT_SUM;
            ctl.cin     = ccr.icc.c;        // Carry from last writer
         end
         exu_pkg::OP_SUB: begin
            ctl.out_sel = exu_pkg::OUT_SUM;
            ctl.invert  = 1'b1;
            ctl.cin     = 1'b1;             // Two's complement
         end
         exu_pkg::OP_SUBC: begin
            ctl.out_sel = exu_pkg::OUT_SUM;
            ctl.invert  = 1'b1;
            ctl.cin     = ~ccr.icc.c;       // Minus borrow
         end
         exu_pkg::OP_AND:   ctl.log_sel = exu_pkg::LOG_AND;
         exu_pkg::OP_ANDN: begin
            ctl.log_sel = exu_pkg::LOG_AND;
            ctl.invert  = 1'b1;
         end
         exu_pkg::OP_OR:    ctl.log_sel = exu_pkg::LOG_OR;
         exu_pkg::OP_ORN: begin
            ctl.log_sel = exu_pkg::LOG_OR;
            ctl.invert  = 1'b1;
         end
         exu_pkg::OP_XOR:   ctl.log_sel = exu_pkg::LOG_XOR;
         exu_pkg::OP_XNOR: begin
            ctl.log_sel = exu_pkg::LOG_XOR;
            ctl.invert  = 1'b1;
         end
         exu_pkg::OP_SETHI: ctl.sethi = 1'b1;
         exu_pkg::OP_SLL: begin
            ctl.out_sel    = exu_pkg::OUT_SHIFT;
            ctl.shift_left = 1'b1;
         end
         exu_pkg::OP_SRL:   ctl.out_sel = exu_pkg::OUT_SHIFT;
         exu_pkg::OP_SRA: begin
            ctl.out_sel     = exu_pkg::OUT_SHIFT;
            ctl.shift_arith = 1'b1;
         end
         exu_pkg::OP_CAS: begin
            ctl.out_sel = exu_pkg::OUT_RS3;
            ctl.casa    = 1'b1;
         end
         default: ;                         // MOV, logic move of rs2
      endcase
   end

   // New codes, add or logic flags by own decode
   always_comb begin
      ccr_nxt.icc.z = flags.zlow;
      ccr_nxt.xcc.z = flags.zlow & flags.zhigh;
      if (is_arith) begin
         ccr_nxt.icc.n = flags.add_n32;
         ccr_nxt.xcc.n = flags.add_n64;
         ccr_nxt.icc.v = flags.v32;
         ccr_nxt.xcc.v = flags.v64;
         ccr_nxt.icc.c = flags.cout32 ^ is_sub;
         ccr_nxt.xcc.c = flags.cout64 ^ is_sub;
      end else begin
         ccr_nxt.icc.n = flags.log_n32;
         ccr_nxt.xcc.n = flags.log_n64;
         ccr_nxt.icc.v = 1'b0;
         ccr_nxt.xcc.v = 1'b0;
         ccr_nxt.icc.c = 1'b0;
         ccr_nxt.xcc.c = 1'b0;
      end
   end

   always_ff @(posedge rclk) begin
      if (reset)
         ccr <= '0;
      else if (e_valid && set_cc_e && cc_ok)
         ccr <= ccr_nxt;   // Ready for a dependent op next cycle
   end

endmodule

// ==== exu_flags_if.sv ====
/*
 Result flags returned from the ALU to the control block, which
 folds them into the condition code register at the end of E.
*/
`timescale 1ns/1ps

interface exu_flags_if;
   logic add_n64, add_n32;   // Sign of sum
   logic log_n64, log_n32;   // Sign of logic result
   logic zhigh, zlow;        // Upper and lower word zero
   logic cout64, cout32;     // Raw adder carries
   logic v64, v32;           // Signed overflow

   modport producer (output add_n64, add_n32, log_n64, log_n32, zhigh, zlow,
                     cout64, cout32, v64, v32);
   modport consumer (input  add_n64, add_n32, log_n64, log_n32, zhigh, zlow,
                     cout64, cout32, v64, v32);
endinterface

// ==== exu_input.txt ====
// First word: vector count. Then one op per line, all hex:
// op set_cc rs1 rs2 rs3 | expected rd_data va addr_err ccr
23
0 1 1 2 0 3 3 0 00
0 1 7FFFFFFF 1 0 80000000 80000000 0 0A
0 1 FFFFFFFFFFFFFFFF 1 0 0 0 0 55
1 1 0 0 0 1 0 0 00
0 1 FFFFFFFFFFFFFFFF 2 0 1 1 0 11
1 1 FFFFFFFF 0 0 100000000 FFFFFFFF 0 05
1 1 10 20 0 31 30 0 00
2 1 5 7 0 FFFFFFFFFFFFFFFE C 0 99
3 1 10 3 0 C 13 0 00
2 1 8000000000000000 1 0 7FFFFFFFFFFFFFFF 1 1 29
2 1 12345678 12345678 0 0 2468ACF0 0 44
0 0 3 4 0 7 7 0 44
4 1 F0F0F0F0 FF00FF00 0 F000F000 1EFF1EFF0 0 08
5 1 F0F0F0F0 FF00FF00 0 F000F0 1EFF1EFF0 0 00
6 1 F0F0F0F0 FF00FF00 0 FFF0FFF0 1EFF1EFF0 0 08
7 1 F0F0F0F0 FF00FF00 0 FFFFFFFFF0FFF0FF 1EFF1EFF0 0 88
8 1 F0F0F0F0 FF00FF00 0 FF00FF0 1EFF1EFF0 0 00
9 1 F0F0F0F0 FF00FF00 0 FFFFFFFFF00FF00F 1EFF1EFF0 0 88
A 0 0 DEADBEEFCAFEF00D 0 DEADBEEFCAFEF00D BEEFCAFEF00D 1 88
B 1 0 DEADBEEFCAFEF00D 0 CAFEF00D BEEFCAFEF00D 1 08
A 1 0 0 0 0 0 0 44
A 1 0 FFFFFFFF00000000 0 FFFFFFFF00000000 FFFF00000000 0 84
C 1 8000000000000001 0 0 8000000000000001 1 1 84
C 1 8000000000000001 1 0 2 2 1 84
C 1 8000000000000001 1F 0 80000000 20 1 84
D 1 8000000000000001 20 0 80000000 21 1 84
E 1 8000000000000001 3F 0 FFFFFFFFFFFFFFFF 40 1 84
E 1 8000000000000001 1 0 C000000000000000 2 1 84
D 1 8000000000000001 3F 0 1 40 1 84
E 1 80000000 20 0 0 80000020 0 84
C 1 12345678 20 0 1234567800000000 12345698 0 84
D 1 FFFFFFFF00000000 1F 0 1FFFFFFFE FFFF0000001F 0 84
F 1 7FFFFFFFFFF8 100 123456789ABCDEF 123456789ABCDEF 7FFFFFFFFFF8 0 84
F 1 800000000000 0 5 5 800000000000 1 84
0 1 FFFF800000000000 10 0 FFFF800000000010 800000000010 0 80

// ==== exu_logic.sv ====
/*
 Logic unit of the ALU: and, or, xor or pass of b, with b optionally
 inverted. SETHI uses the pass path with the upper word cleared.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_logic (
   input  logic               [`EXU_DW-1:0] a,
   input  logic               [`EXU_DW-1:0] b,
   input  logic                             invert,
   input  exu_pkg::log_sel_e                log_sel,
   input  logic                             sethi,
   output logic               [`EXU_DW-1:0] result
);

   localparam int HW = `EXU_DW / 2;

   logic [`EXU_DW-1:0] b_eff;

   assign b_eff = invert ? ~b : b;   // andn, orn, xnor

   always_comb begin
      case (log_sel)
         exu_pkg::LOG_AND: result = a & b_eff;
         exu_pkg::LOG_OR:  result = a | b_eff;
         exu_pkg::LOG_XOR: result = a ^ b_eff;
         default:          result = sethi ? {{HW{1'b0}}, b_eff[HW-1:0]} : b_eff;
      endcase
   end

endmodule

// ==== exu_pkg.sv ====
/*
 Shared types of the execute stage: opcode, select encodings and
 condition codes. Referenced by scoped name from the design files.
*/
package exu_pkg;

   // Issued opcode, ordering groups arithmetic ops at the bottom
   typedef enum logic [3:0] {
      OP_ADD,  OP_ADDC, OP_SUB,   OP_SUBC,
      OP_AND,  OP_ANDN, OP_OR,    OP_ORN,
      OP_XOR,  OP_XNOR, OP_MOV,   OP_SETHI,
      OP_SLL,  OP_SRL,  OP_SRA,   OP_CAS
   } alu_op_e;

   typedef enum logic [1:0] {OUT_SUM, OUT_RS3, OUT_SHIFT, OUT_LOGIC} out_sel_e;
   typedef enum logic [1:0] {LOG_AND, LOG_OR, LOG_XOR, LOG_MOVE} log_sel_e;

   typedef struct packed {
      logic n;   // Negative
      logic z;   // Zero
      logic v;   // Signed overflow
      logic c;   // Carry, or borrow on subtract
   } cc_t;

   typedef struct packed {
      cc_t xcc;  // 64-bit codes, upper nibble
      cc_t icc;  // 32-bit codes
   } ccr_t;

endpackage

// ==== exu_shift.sv ====
/*
 Barrel shifter. One stage per amount bit; right shifts fill with
 zero, or with the sign bit when shift_arith is set.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_shift (
   input  logic [`EXU_DW-1:0]  a,
   input  logic [`EXU_SHW-1:0] amount,
   input  logic                shift_left,
   input  logic                shift_arith,
   output logic [`EXU_DW-1:0]  result
);

   logic fill;   // Bit shifted in from the top

   assign fill = shift_arith & a[`EXU_DW-1];

   always_comb begin
      logic [`EXU_DW-1:0] stage;
      logic [`EXU_DW-1:0] top_mask;
      stage = a;
      for (int i = 0; i < `EXU_SHW; i++) begin
         top_mask = ~({`EXU_DW{1'b1}} >> (1 << i));   // Vacated upper bits
         if (amount[i]) begin
            if (shift_left)
               stage = stage << (1 << i);
            else
               stage = (stage >> (1 << i)) | (fill ? top_mask : '0);
         end
      end
      result = stage;
   end

endmodule

// ==== exu_top.f ====
+incdir+.
exu_pkg.sv
exu_ctl_if.sv
exu_flags_if.sv
exu_addsub.sv
exu_logic.sv
exu_shift.sv
exu_ecl.sv
exu_alu.sv
exu_top.sv
tb_exu_top.sv

// ==== exu_top.sv ====
/*
 Top level of the execute stage. Ties the control block to the ALU
 through the control and flag interfaces; all ports are plain.
 Issue is a one-cycle strobe, done follows one cycle later.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_top (
   input  logic                rclk,
   input  logic                reset,
   input  logic                issue,     // One op per strobe, no stall
   input  exu_pkg::alu_op_e    op,
   input  logic                set_cc,
   input  logic [`EXU_DW-1:0]  rs1,
   input  logic [`EXU_DW-1:0]  rs2,
   input  logic [`EXU_DW-1:0]  rs3,
   output logic                done,
   output logic [`EXU_DW-1:0]  rd_data,
   output logic [`EXU_VAW-1:0] va,
   output logic                addr_err,
   output logic                rs1_zero,
   output logic                rs1_neg,
   output logic [7:0]          ccr        // xcc in [7:4], icc in [3:0]
);

   exu_ctl_if   ctl_if ();
   exu_flags_if flags_if ();

   exu_ecl u_ecl (
      .rclk(rclk), .reset(reset), .issue(issue), .op(op), .set_cc(set_cc),
      .ctl(ctl_if.controller), .flags(flags_if.consumer), .ccr(ccr)
   );

   exu_alu u_alu (
      .rclk(rclk), .reset(reset), .issue(issue),
      .rs1(rs1), .rs2(rs2), .rs3(rs3),
      .ctl(ctl_if.datapath), .flags(flags_if.producer),
      .done(done), .rd_data(rd_data), .va(va), .addr_err(addr_err),
      .rs1_zero(rs1_zero), .rs1_neg(rs1_neg)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_exu_top -f exu_top.f -o tb_exu_top \
   > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $BUILD_LOG"
   exit 1
fi

./obj_dir/tb_exu_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "test failed" "$SIM_LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
exit 0

// ==== tb_exu_top.sv ====
/*
 Testbench for the execute stage. Loads op vectors and expected results
 from exu_input.txt, issues them with random idle gaps (carry ops always
 back-to-back) and checks each done pulse against the expected values.
 Built and run by run_sim.sh.
*/
`timescale 1ns/1ps
`include "exu_consts.svh"

module tb_exu_top;

   localparam int MAX_VEC = 64;
   localparam int FIELDS  = 9;   // Words per vector line
   localparam int F_CC    = 1;
   localparam int F_RS1   = 2;
   localparam int F_RS2   = 3;
   localparam int F_RS3   = 4;
   localparam int F_RD    = 5;
   localparam int F_VA    = 6;
   localparam int F_AERR  = 7;
   localparam int F_CCR   = 8;

   logic                rclk;
   logic                reset;
   logic                issue;
   exu_pkg::alu_op_e    op;
   logic                set_cc;
   logic [`EXU_DW-1:0]  rs1;
   logic [`EXU_DW-1:0]  rs2;
   logic [`EXU_DW-1:0]  rs3;
   logic                done;
   logic [`EXU_DW-1:0]  rd_data;
   logic [`EXU_VAW-1:0] va;
   logic                addr_err;
   logic                rs1_zero;
   logic                rs1_neg;
   logic [7:0]          ccr;

   logic [63:0] vec_mem [0:FIELDS*MAX_VEC];   // Word 0 holds the count
   int          num_vec;
   int          exp_q[$];            // Vector indices awaiting done
   logic        issue_q;             // Issue sampled by the DUT, op now in E
   logic        done_exp;            // Op leaving E, done due now
   int          cycle_count;
   int          cycle_limit = 1000;  // Replaced once vectors are loaded
   int          error_count;
   int          idx;
   int          base;

   exu_top u_exu_top (
      .rclk(rclk), .reset(reset), .issue(issue), .op(op), .set_cc(set_cc),
      .rs1(rs1), .rs2(rs2), .rs3(rs3),
      .done(done), .rd_data(rd_data), .va(va), .addr_err(addr_err),
      .rs1_zero(rs1_zero), .rs1_neg(rs1_neg), .ccr(ccr)
   );

   always #4 rclk = ~rclk;   // 8 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         $display("test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Reference for the done timing, one cycle after the issue edge
   always @(posedge rclk) begin
      if (reset) begin
         issue_q  <= 1'b0;
         done_exp <= 1'b0;
      end else begin
         issue_q  <= issue;
         done_exp <= issue_q;
      end
   end

   // Sample mid-cycle where outputs are settled
   always @(negedge rclk) begin
      if (!reset) begin
         check_value("done", 64'(done), 64'(done_exp));   // One pulse per issue
         if (done) begin
            if (exp_q.size() == 0) begin
               $display("done pulse seen with no operation outstanding");
               $display("test failed");
               $fatal(1, "unexpected done");
            end else begin
               idx  = exp_q.pop_front();
               base = 1 + idx * FIELDS;
               check_value("rd_data", rd_data, vec_mem[base+F_RD]);
               check_value("va", 64'(va), vec_mem[base+F_VA]);
               check_value("addr_err", 64'(addr_err), vec_mem[base+F_AERR]);
               check_value("ccr", 64'(ccr), vec_mem[base+F_CCR]);
               check_value("rs1_zero", 64'(rs1_zero), 64'(vec_mem[base+F_RS1] == 64'd0));
               check_value("rs1_neg", 64'(rs1_neg), 64'(vec_mem[base+F_RS1][63]));
            end
         end
      end
   end

   // Run limit from reset length and vector count
   always @(posedge rclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("test failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      logic [31:0] rnd;
      logic [3:0]  op_code;
      int          gap;
      int          vb;
      rclk        = 1'b0;
      reset       = 1'b1;
      issue       = 1'b0;
      op          = exu_pkg::OP_ADD;
      set_cc      = 1'b0;
      rs1         = '0;
      rs2         = '0;
      rs3         = '0;
      cycle_count = 0;
      error_count = 0;
      rnd         = 32'h9c29;

      $readmemh("exu_input.txt", vec_mem);
      num_vec = int'(vec_mem[0][15:0]);
      if (num_vec < 1 || num_vec > MAX_VEC) begin
         $display("vector file holds a bad count of %0d vectors", num_vec);
         $display("test failed");
         $fatal(1, "bad vector file");
      end
      cycle_limit = 10 + 4 * num_vec + 50;

      repeat (10) @(posedge rclk);
      reset <= 1'b0;
      @(negedge rclk);
      check_value("done", 64'(done), 64'd0);        // Cleared state
      check_value("rd_data", rd_data, 64'd0);
      check_value("ccr", 64'(ccr), 64'd0);

      for (int vi = 0; vi < num_vec; vi++) begin
         rnd     = xorshift32(rnd);
         vb      = 1 + vi * FIELDS;
         op_code = vec_mem[vb][3:0];
         gap     = 0;
         // Carry consumers stay glued to their producer
         if (op_code != exu_pkg::OP_ADDC && op_code != exu_pkg::OP_SUBC && rnd[0])
            gap = 1 + int'(rnd[4]);
         repeat (gap) begin
            @(posedge rclk);
            issue <= 1'b0;
         end
         @(posedge rclk);
         issue  <= 1'b1;
         op     <= exu_pkg::alu_op_e'(op_code);
         set_cc <= vec_mem[vb+F_CC][0];
         rs1    <= vec_mem[vb+F_RS1];
         rs2    <= vec_mem[vb+F_RS2];
         rs3    <= vec_mem[vb+F_RS3];
         exp_q.push_back(vi);
      end
      @(posedge rclk);
      issue <= 1'b0;

      while (exp_q.size() != 0)
         @(posedge rclk);
      repeat (3) @(posedge rclk);   // No stray done after the last op

      if (error_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
